//--- Makefile
BIN     := obj_dir/Vtb_bnn_classifier
SOURCES := $(shell grep -v '^+' vlog.f)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when the file list or a source changes.
$(BIN): vlog.f $(SOURCES)
	verilator --binary --timing --assert -j 0 \
		--top-module tb_bnn_classifier -f vlog.f

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- hdl/bnn_classifier.sv
`timescale 1ns/10ps
`default_nettype none

module bnn_classifier (
    input  wire logic                                            clk,
    input  wire logic                                            reset,
    input  wire logic [bnn_pkg::FEAT_CNT*bnn_pkg::FEAT_BITS-1:0] features,
    input  wire logic                                            features_valid,
    output logic [bnn_pkg::CLASS_BITS-1:0]                       prediction,
    output logic                                                 prediction_valid
);

    import bnn_pkg::*;

    hidden_vec_t hidden;
    logic        hidden_valid;
    score_vec_t  scores;
    logic        scores_valid;

    // Three stages, one cycle each.
    hidden_layer hidden_layer_inst (
        .clk            (clk),
        .reset          (reset),
        .features       (features),
        .features_valid (features_valid),
        .hidden         (hidden),
        .hidden_valid   (hidden_valid)
    );

    output_layer output_layer_inst (
        .clk          (clk),
        .reset        (reset),
        .hidden       (hidden),
        .hidden_valid (hidden_valid),
        .scores       (scores),
        .scores_valid (scores_valid)
    );

    class_argmax class_argmax_inst (
        .clk              (clk),
        .reset            (reset),
        .scores           (scores),
        .scores_valid     (scores_valid),
        .prediction       (prediction),
        .prediction_valid (prediction_valid)
    );

endmodule

`default_nettype wire

//--- hdl/bnn_pkg.sv
`default_nettype none

package bnn_pkg;

    // Network shape.
    localparam int FEAT_CNT   = 11;
    localparam int FEAT_BITS  = 4;
    localparam int HIDDEN_CNT = 40;
    localparam int CLASS_CNT  = 6;
    localparam int CLASS_BITS = $clog2(CLASS_CNT);

    // Holds a full agreement count of 0 to HIDDEN_CNT.
    localparam int SCORE_BITS = $clog2(HIDDEN_CNT + 1);

    // Magnitude of the largest possible sum, plus a sign bit.
    localparam int NEURON_SUM_BITS = $clog2(FEAT_CNT * (2 ** FEAT_BITS - 1) + 1) + 1;

    // Feature 0 sits in the low bits.
    typedef logic [FEAT_CNT-1:0][FEAT_BITS-1:0] feature_vec_t;

    // Neuron 0 sits in bit 0.
    typedef logic [HIDDEN_CNT-1:0] hidden_vec_t;

    // Class 0 score sits in the low slice.
    typedef logic [CLASS_CNT-1:0][SCORE_BITS-1:0] score_vec_t;

    typedef logic [CLASS_BITS-1:0] class_t;

    // One row per neuron. Bits run from feature 10 down to feature 0.
    // A set bit adds the feature to the neuron sum.
    // A clear bit subtracts it.
    localparam logic [FEAT_CNT-1:0] HIDDEN_WEIGHTS [HIDDEN_CNT] = '{
        // Neurons 0 to 9.
        11'b00110011000,
        11'b00111000000,
        11'b00011001000,
        11'b10100000101,
        11'b00100000111,
        11'b10101011011,
        11'b11100011001,
        11'b10100101110,
        11'b00110110000,
        11'b11111010111,

        // Neurons 10 to 19.
        11'b10000000110,
        11'b11011110000,
        11'b11111000101,
        11'b01110001101,
        11'b00101010011,
        11'b11101110111,
        11'b01010011110,
        11'b10101001110,
        11'b11111100000,
        11'b00010101100,

        // Neurons 20 to 29.
        11'b00010111011,
        11'b11101111111,
        11'b01101011101,
        11'b11100000001,
        11'b01100111000,
        11'b00000111100,
        11'b10111001100,
        11'b11010100001,
        11'b00110101000,
        11'b00111010011,

        // Neurons 30 to 39.
        11'b10000111110,
        11'b01001010100,
        11'b00001110001,
        11'b01100010011,
        11'b10110110001,
        11'b11111110110,
        11'b11011110110,
        11'b11001100100,
        11'b11110010010,
        11'b11101100111
    };

    // One row per class. Bits run from neuron 39 down to neuron 0.
    // A set bit scores a point when the hidden bit is 1.
    // A clear bit scores a point when the hidden bit is 0.
    localparam hidden_vec_t OUTPUT_WEIGHTS [CLASS_CNT] = '{
        40'b0010_0010_1111_0000_0011_0111_0000_0100_0011_1001,
        40'b1100_0110_1000_0001_1011_1000_0001_1101_0011_1101,
        40'b1010_1110_0011_0110_0010_0010_0001_0010_0000_0011,
        40'b1000_1010_1111_1101_1110_0101_0101_0010_1100_0101,
        40'b0110_1110_1100_1111_1110_0100_1111_0100_1000_1110,
        40'b1010_1111_0101_0101_1110_1111_0101_0100_0101_1110
    };

endpackage

`default_nettype wire

//--- hdl/class_argmax.sv
`timescale 1ns/10ps
`default_nettype none

module class_argmax (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire bnn_pkg::score_vec_t scores,
    input  wire logic                scores_valid,
    output bnn_pkg::class_t          prediction,
    output logic                     prediction_valid
);

    import bnn_pkg::*;

    class_t                best_idx;
    logic [SCORE_BITS-1:0] best_score;

    // Ascending scan. Only a strictly higher score takes over,
    // so the lowest index wins a tie.
    always_comb begin
        best_idx   = '0;
        best_score = scores[0];
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (scores[c] > best_score) begin
                best_idx   = class_t'(c);
                best_score = scores[c];
            end
        end
    end

    // Holds the last winner between strobes.
    always_ff @(posedge clk) begin
        if (reset) begin
            prediction <= '0;
        end else if (scores_valid) begin
            prediction <= best_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prediction_valid <= 1'b0;
        end else begin
            prediction_valid <= scores_valid;
        end
    end

endmodule

`default_nettype wire

//--- hdl/hidden_layer.sv
`timescale 1ns/10ps
`default_nettype none

module hidden_layer (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire bnn_pkg::feature_vec_t features,
    input  wire logic                 features_valid,
    output bnn_pkg::hidden_vec_t      hidden,
    output logic                      hidden_valid
);

    import bnn_pkg::*;

    feature_vec_t features_q;
    logic         features_q_valid;
    hidden_vec_t  hidden_next;

    // Input capture.
    always_ff @(posedge clk) begin
        if (features_valid) begin
            features_q <= features;
        end
    end

    for (genvar n = 0; n < HIDDEN_CNT; n++) begin : gen_neuron
        logic signed [NEURON_SUM_BITS-1:0] sum;

        always_comb begin
            logic signed [NEURON_SUM_BITS-1:0] term;

            sum = '0;
            for (int f = 0; f < FEAT_CNT; f++) begin
                term = NEURON_SUM_BITS'(features_q[f]);
                if (HIDDEN_WEIGHTS[n][f]) begin
                    sum = sum + term;
                end else begin
                    sum = sum - term;
                end
            end
        end

        // Fires on a zero or positive sum.
        assign hidden_next[n] = (sum >= 0);
    end

    always_ff @(posedge clk) begin
        if (features_q_valid) begin
            hidden <= hidden_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            features_q_valid <= 1'b0;
            hidden_valid     <= 1'b0;
        end else begin
            features_q_valid <= features_valid;
            hidden_valid     <= features_q_valid;
        end
    end

endmodule

`default_nettype wire

//--- hdl/output_layer.sv
`timescale 1ns/10ps
`default_nettype none

module output_layer (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire bnn_pkg::hidden_vec_t hidden,
    input  wire logic                 hidden_valid,
    output bnn_pkg::score_vec_t       scores,
    output logic                      scores_valid
);

    import bnn_pkg::*;

    score_vec_t scores_next;

    // XNOR against each class row, then popcount.
    always_comb begin
        hidden_vec_t agree;

        for (int c = 0; c < CLASS_CNT; c++) begin
            agree = ~(hidden ^ OUTPUT_WEIGHTS[c]);
            scores_next[c] = '0;
            for (int h = 0; h < HIDDEN_CNT; h++) begin
                scores_next[c] = scores_next[c] + SCORE_BITS'(agree[h]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hidden_valid) begin
            scores <= scores_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scores_valid <= 1'b0;
        end else begin
            scores_valid <= hidden_valid;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_bnn_classifier.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bnn_classifier;

    import bnn_pkg::*;

    localparam int          CLK_PERIOD    = 10;
    localparam int          RESET_CYCLES  = 2;
    localparam int          TEST_CNT      = 1000;
    localparam int          LATENCY       = 3;
    localparam int          MAX_GAP       = 4;
    localparam int          DRAIN_LIMIT   = 8 * LATENCY;
    localparam int          MARGIN_CYCLES = 500;
    localparam int          WATCHDOG_CYCLES =
        TEST_CNT * (MAX_GAP + 1 + LATENCY) + MARGIN_CYCLES;
    localparam logic [31:0] LCG_SEED      = 32'hc200_10c7;

    logic         clk = 1'b0;
    logic         reset;
    feature_vec_t features;
    logic         features_valid;
    class_t       prediction;
    logic         prediction_valid;

    logic [31:0]  lcg_state;
    class_t       expected_q[$];
    int           strobe_edge_q[$];
    int           edge_count = 0;
    class_t       held_prediction;
    logic         hold_known = 1'b0;

    bnn_classifier bnn_classifier_inst (
        .clk              (clk),
        .reset            (reset),
        .features         (features),
        .features_valid   (features_valid),
        .prediction       (prediction),
        .prediction_valid (prediction_valid)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic feature_vec_t random_features();
        feature_vec_t fv;
        logic [31:0]  draw;

        for (int k = 0; k < FEAT_CNT; k++) begin
            draw  = lcg_next();
            fv[k] = draw[27:24];
        end
        return fv;
    endfunction

    // Reference network built straight from the weight tables.
    function automatic class_t model_predict(input feature_vec_t fv);
        hidden_vec_t hid;
        int          sum;
        int          score;
        int          best_score;
        class_t      best;

        for (int n = 0; n < HIDDEN_CNT; n++) begin
            sum = 0;
            for (int k = 0; k < FEAT_CNT; k++) begin
                if (HIDDEN_WEIGHTS[n][k]) begin
                    sum = sum + int'(fv[k]);
                end else begin
                    sum = sum - int'(fv[k]);
                end
            end
            hid[n] = (sum >= 0);
        end

        best       = '0;
        best_score = -1;
        for (int c = 0; c < CLASS_CNT; c++) begin
            score = 0;
            for (int h = 0; h < HIDDEN_CNT; h++) begin
                if (hid[h] == OUTPUT_WEIGHTS[c][h]) begin
                    score++;
                end
            end
            if (score > best_score) begin
                best       = class_t'(c);
                best_score = score;
            end
        end
        return best;
    endfunction

    task automatic drive_strobe(input feature_vec_t fv);
        features       = fv;
        features_valid = 1'b1;
        @(negedge clk);
    endtask

    task automatic idle_cycles(input int count);
        features_valid = 1'b0;
        repeat (count) @(negedge clk);
    endtask

    // Outputs are read before this edge updates them,
    // so a result shows up one edge after it is registered.
    always @(posedge clk) begin : scoreboard
        class_t expected;
        int     strobe_edge;

        edge_count++;
        if (prediction_valid) begin
            assert (expected_q.size() != 0) begin
                expected    = expected_q.pop_front();
                strobe_edge = strobe_edge_q.pop_front();
                assert (edge_count - strobe_edge == LATENCY + 1) else
                    stop_on_failure($sformatf(
                        "prediction_valid came %0d cycles after its strobe instead of %0d",
                        edge_count - strobe_edge - 1, LATENCY));
                assert (prediction == expected) else
                    stop_on_failure($sformatf("FAIL prediction: expected 0x%0h, got 0x%0h",
                        expected, prediction));
                held_prediction = expected;
            end else begin
                stop_on_failure("prediction_valid was raised with no vector outstanding");
            end
        end else if (hold_known) begin
            assert (prediction == held_prediction) else
                stop_on_failure($sformatf("FAIL prediction (held): expected 0x%0h, got 0x%0h",
                    held_prediction, prediction));
        end

        // Reset drops everything in flight.
        if (reset) begin
            expected_q.delete();
            strobe_edge_q.delete();
            held_prediction = '0;
            hold_known      = 1'b1;
        end else if (features_valid) begin
            expected_q.push_back(model_predict(features));
            strobe_edge_q.push_back(edge_count);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_failure("Timeout: the run did not finish in time");
    end

    initial begin : stimulus
        logic [31:0] draw;
        int          gap;
        int          drain_cycles;

        lcg_state      = LCG_SEED;
        features       = '0;
        features_valid = 1'b0;
        reset          = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Quiet pipeline after reset.
        idle_cycles(8);

        // Back-to-back strobes.
        repeat (TEST_CNT / 2) begin
            drive_strobe(random_features());
        end

        // Strobes with random idle gaps.
        repeat (TEST_CNT / 2) begin
            drive_strobe(random_features());
            draw = lcg_next();
            gap  = int'(draw[23:16]) % (MAX_GAP + 1);
            idle_cycles(gap);
        end

        // Corner vectors spaced apart and then back to back.
        idle_cycles(4);
        drive_strobe('0);
        idle_cycles(2);
        drive_strobe({FEAT_CNT{4'hf}});
        idle_cycles(2);
        drive_strobe('0);
        drive_strobe({FEAT_CNT{4'hf}});
        idle_cycles(LATENCY + 3);

        // Reset with three vectors in flight.
        repeat (3) begin
            drive_strobe(random_features());
        end
        features_valid = 1'b0;
        reset          = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        idle_cycles(4);
        repeat (20) begin
            drive_strobe(random_features());
        end
        idle_cycles(0);

        drain_cycles = 0;
        while (expected_q.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            drain_cycles++;
        end
        // Catch any stray result.
        idle_cycles(8);

        if (expected_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_on_failure($sformatf("%0d vectors never produced a prediction",
                expected_q.size()));
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
hdl/bnn_pkg.sv
hdl/hidden_layer.sv
hdl/output_layer.sv
hdl/class_argmax.sv
hdl/bnn_classifier.sv
verification/tb_bnn_classifier.sv
